//--- project.f
hdl/memPkg.sv
hdl/reqQueue.sv
hdl/byteRam.sv
hdl/memCtrl.sv
hdl/memSubsystem.sv
bench/memSubsystem_sva.sv
bench/tbMemSubsystem.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tbMemSubsystem

status=0
./obj_dir/VtbMemSubsystem > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then
    echo "run.sh: simulation reported failure"
    exit 1
fi
echo "run.sh: no failure found in sim.log"

//--- bench/tbMemSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tbMemSubsystem;

    localparam int DrainTimeout = 2000;

    logic clk;
    logic rst;
    logic hold;
    memPkg::instReq_t instReq;
    memPkg::dataReq_t dataReq;
    logic instCredit;
    logic dataCredit;
    memPkg::instRsp_t instRsp;
    memPkg::dataRsp_t dataRsp;

    memPkg::byte_t model [memPkg::MemBytes];
    memPkg::memAddr_t instPend [$];
    memPkg::dataReq_t dataPend [$];
    memPkg::word_t instExp [$];
    memPkg::dataRsp_t dataExp [$];
    int instCredits;
    int dataCredits;
    int mismatches;
    int failures;
    logic [31:0] seed;
    logic holdQuiet;
    logic rstSeen;

    memSubsystem dut (
        .clk(clk),
        .rst(rst),
        .hold(hold),
        .instReq(instReq),
        .instCredit(instCredit),
        .instRsp(instRsp),
        .dataReq(dataReq),
        .dataCredit(dataCredit),
        .dataRsp(dataRsp)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};
    endfunction

    function automatic int byteCountOf(input memPkg::lenCode_t len);
        return (len == memPkg::LenByte) ? 1 : ((len == memPkg::LenHalf) ? 2 : 4);
    endfunction

    // little-endian with the upper bytes left zero
    function automatic memPkg::word_t loadModel(input memPkg::memAddr_t addr, input int n);
        memPkg::word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = model[memPkg::memAddr_t'(addr + i)];
        end
        return w;
    endfunction

    task automatic queueRandomInst(input int count);
        @(negedge clk);
        for (int i = 0; i < count; i++) begin
            instPend.push_back(memPkg::memAddr_t'((nextRand() % 64) * 4));
        end
    endtask

    // data traffic stays above the fetch region without wrapping
    task automatic queueRandomData(input int count);
        memPkg::dataReq_t req;
        @(negedge clk);
        for (int i = 0; i < count; i++) begin
            req.valid = 1'b1;
            req.isStore = 1'(nextRand() % 2);
            req.len = memPkg::lenCode_t'(nextRand() % 3);
            req.addr = memPkg::memAddr_t'(32'd256 + nextRand() % 32'd765);
            req.wdata = nextRand();
            dataPend.push_back(req);
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while ((instPend.size() + dataPend.size() + instExp.size() + dataExp.size() != 0
                || instCredits != memPkg::QueueDepth || dataCredits != memPkg::QueueDepth)
               && cycles < DrainTimeout) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= DrainTimeout) begin
            failures++;
            $display("%0t: timeout, requests or credits still outstanding", $time);
        end
    endtask

    always @(posedge clk) begin : instDriver
        memPkg::memAddr_t addr;
        if (!rst && instPend.size() > 0 && instCredits > 0) begin
            addr = instPend.pop_front();
            instReq <= {1'b1, addr};
            instExp.push_back(loadModel(addr, 4));
            instCredits--;
        end else begin
            instReq.valid <= 1'b0;
        end
    end

    // expected values follow issue order and stores update the model here
    always @(posedge clk) begin : dataDriver
        memPkg::dataReq_t req;
        memPkg::dataRsp_t exp;
        if (!rst && dataPend.size() > 0 && dataCredits > 0) begin
            req = dataPend.pop_front();
            dataReq <= req;
            exp.valid = 1'b1;
            exp.isStore = req.isStore;
            exp.rdata = req.isStore ? '0 : loadModel(req.addr, byteCountOf(req.len));
            if (req.isStore) begin
                for (int i = 0; i < byteCountOf(req.len); i++) begin
                    model[memPkg::memAddr_t'(req.addr + i)] = req.wdata[8*i +: 8];
                end
            end
            dataExp.push_back(exp);
            dataCredits--;
        end else begin
            dataReq.valid <= 1'b0;
        end
    end

    always @(negedge clk) begin : respMonitor
        memPkg::word_t expInst;
        memPkg::dataRsp_t exp;
        if (instCredit) begin
            instCredits++;
        end
        if (dataCredit) begin
            dataCredits++;
        end
        assert (instCredits >= 0 && instCredits <= memPkg::QueueDepth
                && dataCredits >= 0 && dataCredits <= memPkg::QueueDepth) else begin
            failures++;
            $display("%0t: credit count out of range (inst %0d, data %0d)",
                     $time, instCredits, dataCredits);
        end
        if (rst || rstSeen) begin
            assert (!instRsp.valid && !dataRsp.valid && !instCredit && !dataCredit) else begin
                failures++;
                $display("%0t: response valid or credit pulse around reset", $time);
            end
        end
        rstSeen = rst;
        if (holdQuiet) begin
            assert (!instRsp.valid && !dataRsp.valid) else begin
                failures++;
                $display("%0t: response finished while hold was high", $time);
            end
        end
        if (instRsp.valid && instExp.size() == 0) begin
            failures++;
            $display("%0t: instruction response without a request", $time);
        end else if (instRsp.valid) begin
            expInst = instExp.pop_front();
            assert (instRsp.inst == expInst) else begin
                mismatches++;
                $display("MISMATCH %0t instRsp.inst expected %h actual %h",
                         $time, expInst, instRsp.inst);
            end
        end
        if (dataRsp.valid && dataExp.size() == 0) begin
            failures++;
            $display("%0t: data response without a request", $time);
        end else if (dataRsp.valid) begin
            exp = dataExp.pop_front();
            assert (dataRsp.isStore == exp.isStore) else begin
                mismatches++;
                $display("MISMATCH %0t dataRsp.isStore expected %b actual %b",
                         $time, exp.isStore, dataRsp.isStore);
            end
            assert (dataRsp.rdata == exp.rdata) else begin
                mismatches++;
                $display("MISMATCH %0t dataRsp.rdata expected %h actual %h",
                         $time, exp.rdata, dataRsp.rdata);
            end
        end
    end

    initial begin : stimulus
        memPkg::dataReq_t req;
        int span;
        clk = 1'b0;
        rst = 1'b1;
        hold = 1'b0;
        instReq = '0;
        dataReq = '0;
        seed = 32'hcc2f2b51;
        instCredits = memPkg::QueueDepth;
        dataCredits = memPkg::QueueDepth;
        mismatches = 0;
        failures = 0;
        holdQuiet = 1'b0;
        rstSeen = 1'b0;
        for (int i = 0; i < memPkg::MemBytes; i++) begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // preload the fetch region with word stores and fetch from it
        @(negedge clk);
        for (int a = 0; a < 256; a += 4) begin
            req = {1'b1, 1'b1, memPkg::LenWord, memPkg::memAddr_t'(a), nextRand()};
            dataPend.push_back(req);
        end
        drain();
        queueRandomInst(20);
        drain();

        // data client alone
        queueRandomData(60);
        drain();

        // both clients back to back
        queueRandomInst(40);
        queueRandomData(40);
        drain();

        // hold rises with traffic queued
        queueRandomInst(8);
        queueRandomData(8);
        repeat (3) @(posedge clk);
        hold <= 1'b1;
        repeat (5) @(posedge clk);
        holdQuiet = 1'b1;
        span = 10 + int'(nextRand() % 31);
        repeat (span) @(posedge clk);
        holdQuiet = 1'b0;
        hold <= 1'b0;
        drain();

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/memSubsystem_sva.sv
`timescale 1ns/100ps
`default_nettype none

module memSubsystem_sva (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                instPush,
    input wire logic                dataPush,
    input wire logic                instPop,
    input wire logic                dataPop,
    input wire logic                instCredit,
    input wire logic                dataCredit,
    input wire memPkg::queueCount_t instCount,
    input wire memPkg::queueCount_t dataCount,
    input wire logic                ramEn,
    input wire logic                instRspValid,
    input wire logic                dataRspValid
);

    localparam memPkg::queueCount_t Full = memPkg::queueCount_t'(memPkg::QueueDepth);

    instNoOverflow: assert property (@(posedge clk) disable iff (rst)
        instPush |-> (instCount != Full)) else $error("instruction queue pushed while full");
    dataNoOverflow: assert property (@(posedge clk) disable iff (rst)
        dataPush |-> (dataCount != Full)) else $error("data queue pushed while full");

    // a credit comes back only for an entry popped the cycle before
    instCreditAfterPop: assert property (@(posedge clk) disable iff (rst)
        instCredit |-> $past(instPop)) else $error("instruction credit without a pop");
    dataCreditAfterPop: assert property (@(posedge clk) disable iff (rst)
        dataCredit |-> $past(dataPop)) else $error("data credit without a pop");

    ramIdleAfterReset: assert property (@(posedge clk)
        rst |=> !ramEn) else $error("RAM enabled right after reset");

    oneResponse: assert property (@(posedge clk) disable iff (rst)
        !(instRspValid && dataRspValid)) else $error("both response valids high");

endmodule

bind memSubsystem memSubsystem_sva sva (
    .clk(clk),
    .rst(rst),
    .instPush(instReq.valid),
    .dataPush(dataReq.valid),
    .instPop(instPop),
    .dataPop(dataPop),
    .instCredit(instCredit),
    .dataCredit(dataCredit),
    .instCount(instQueue.count),
    .dataCount(dataQueue.count),
    .ramEn(ramReq.en),
    .instRspValid(instRsp.valid),
    .dataRspValid(dataRsp.valid)
);

`default_nettype wire

//--- hdl/memSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module memSubsystem (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             hold,

    input  wire memPkg::instReq_t instReq,
    output logic                  instCredit,
    output memPkg::instRsp_t      instRsp,

    input  wire memPkg::dataReq_t dataReq,
    output logic                  dataCredit,
    output memPkg::dataRsp_t      dataRsp
);

    memPkg::instReq_t instHead;
    logic instValid;
    logic instPop;

    memPkg::dataReq_t dataHead;
    logic dataValid;
    logic dataPop;

    memPkg::ramReq_t ramReq;
    memPkg::byte_t ramRdata;

    reqQueue #(
        .PayloadType(memPkg::instReq_t)
    ) instQueue (
        .clk(clk),
        .rst(rst),
        .push(instReq.valid),
        .pushData(instReq),
        .pop(instPop),
        .head(instHead),
        .notEmpty(instValid),
        .creditReturn(instCredit)
    );

    reqQueue #(
        .PayloadType(memPkg::dataReq_t)
    ) dataQueue (
        .clk(clk),
        .rst(rst),
        .push(dataReq.valid),
        .pushData(dataReq),
        .pop(dataPop),
        .head(dataHead),
        .notEmpty(dataValid),
        .creditReturn(dataCredit)
    );

    memCtrl ctrl (
        .clk(clk),
        .rst(rst),
        .hold(hold),
        .instHead(instHead),
        .instValid(instValid),
        .instPop(instPop),
        .dataHead(dataHead),
        .dataValid(dataValid),
        .dataPop(dataPop),
        .ramReq(ramReq),
        .ramRdata(ramRdata),
        .instRsp(instRsp),
        .dataRsp(dataRsp)
    );

    byteRam ram (
        .clk(clk),
        .ramReq(ramReq),
        .rdata(ramRdata)
    );

endmodule

`default_nettype wire

//--- hdl/memCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module memCtrl (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             hold,

    input  wire memPkg::instReq_t instHead,
    input  wire logic             instValid,
    output logic                  instPop,

    input  wire memPkg::dataReq_t dataHead,
    input  wire logic             dataValid,
    output logic                  dataPop,

    output memPkg::ramReq_t       ramReq,
    input  wire memPkg::byte_t    ramRdata,

    output memPkg::instRsp_t      instRsp,
    output memPkg::dataRsp_t      dataRsp
);

    memPkg::ctrlState_t state;
    memPkg::stage_t stage;

    memPkg::memAddr_t addr;
    memPkg::lenCode_t len;
    memPkg::word_t shiftReg;

    memPkg::stage_t byteCount;
    memPkg::stage_t headCount;
    memPkg::word_t loadWord;
    logic startData;
    logic startInst;
    logic startByteStore;
    logic readLast;
    logic storeLast;

    function automatic memPkg::stage_t lenBytes(input memPkg::lenCode_t lenCode);
        case (lenCode)
            memPkg::LenByte: return memPkg::stage_t'(1);
            memPkg::LenHalf: return memPkg::stage_t'(2);
            default: return memPkg::stage_t'(4);
        endcase
    endfunction

    // arbitration, data before fetch, hold only blocks a new start
    assign startData = (state == memPkg::Idle) && !hold && dataValid;
    assign startInst = (state == memPkg::Idle) && !hold && !dataValid && instValid;
    assign dataPop = startData;
    assign instPop = startInst;

    assign byteCount = lenBytes(len);
    assign headCount = lenBytes(dataHead.len);

    // a single byte store finishes in the pop cycle itself
    assign startByteStore = startData && dataHead.isStore && (headCount == memPkg::stage_t'(1));

    // reads finish one stage after the last byte was issued
    assign readLast = (stage == byteCount);
    assign storeLast = ((stage + 1'b1) == byteCount);

    // last byte comes straight from the RAM, then align to the low end
    assign loadWord = {ramRdata, shiftReg[31:8]} >> {(3'd4 - byteCount), 3'b000};

    always_comb begin
        ramReq.en = 1'b0;
        ramReq.we = 1'b0;
        ramReq.addr = addr + memPkg::memAddr_t'(stage);
        ramReq.wdata = shiftReg[7:0];
        case (state)
            memPkg::Idle: begin
                if (startData) begin
                    ramReq.en = 1'b1;
                    ramReq.we = dataHead.isStore;
                    ramReq.addr = dataHead.addr;
                    ramReq.wdata = dataHead.wdata[7:0];
                end else if (startInst) begin
                    ramReq.en = 1'b1;
                    ramReq.addr = instHead.addr;
                end
            end
            memPkg::ReadInst, memPkg::ReadData: begin
                ramReq.en = !readLast;
            end
            memPkg::WriteData: begin
                ramReq.en = 1'b1;
                ramReq.we = 1'b1;
            end
            default: begin
                ramReq.en = 1'b0;
            end
        endcase
    end

    always_comb begin
        instRsp.valid = (state == memPkg::ReadInst) && readLast;
        instRsp.inst = loadWord;

        dataRsp.valid = ((state == memPkg::ReadData) && readLast)
                     || ((state == memPkg::WriteData) && storeLast)
                     || startByteStore;
        dataRsp.isStore = (state == memPkg::WriteData) || startByteStore;
        dataRsp.rdata = (state == memPkg::ReadData) ? loadWord : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::Idle;
            stage <= '0;
        end else begin
            case (state)
                memPkg::Idle: begin
                    if (startData) begin
                        stage <= memPkg::stage_t'(1);
                        if (!dataHead.isStore) begin
                            state <= memPkg::ReadData;
                        end else if (!startByteStore) begin
                            state <= memPkg::WriteData;
                        end else begin
                            state <= memPkg::Idle;
                            stage <= '0;
                        end
                    end else if (startInst) begin
                        state <= memPkg::ReadInst;
                        stage <= memPkg::stage_t'(1);
                    end
                end
                memPkg::ReadInst, memPkg::ReadData: begin
                    if (readLast) begin
                        state <= memPkg::Idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end
                memPkg::WriteData: begin
                    if (storeLast) begin
                        state <= memPkg::Idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end
                default: begin
                    state <= memPkg::Idle;
                    stage <= '0;
                end
            endcase
        end
    end

    // request fields latched at the start, shiftReg doubles as
    // store byte source and load assembly register
    always_ff @(posedge clk) begin
        case (state)
            memPkg::Idle: begin
                if (startData) begin
                    addr <= dataHead.addr;
                    len <= dataHead.len;
                    shiftReg <= dataHead.wdata >> 8;
                end else if (startInst) begin
                    addr <= instHead.addr;
                    len <= memPkg::LenWord;
                end
            end
            memPkg::ReadInst, memPkg::ReadData: begin
                shiftReg <= {ramRdata, shiftReg[31:8]};
            end
            memPkg::WriteData: begin
                shiftReg <= shiftReg >> 8;
            end
            default: begin
                shiftReg <= shiftReg;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/byteRam.sv
`timescale 1ns/100ps
`default_nettype none

module byteRam (
    input  wire logic            clk,
    input  wire memPkg::ramReq_t ramReq,
    output memPkg::byte_t        rdata
);

    memPkg::byte_t mem [memPkg::MemBytes];

    initial begin
        for (int i = 0; i < memPkg::MemBytes; i++) begin
            mem[i] = '0;
        end
    end

    // one cycle read latency, rdata holds between reads
    always_ff @(posedge clk) begin
        if (ramReq.en) begin
            if (ramReq.we) begin
                mem[ramReq.addr] <= ramReq.wdata;
            end else begin
                rdata <= mem[ramReq.addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/reqQueue.sv
`timescale 1ns/100ps
`default_nettype none

module reqQueue #(
    parameter type PayloadType = memPkg::instReq_t
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       push,
    input  wire PayloadType pushData,
    input  wire logic       pop,
    output PayloadType      head,
    output logic            notEmpty,
    output logic            creditReturn
);

    PayloadType entries [memPkg::QueueDepth];
    memPkg::queuePtr_t wrPtr;
    memPkg::queuePtr_t rdPtr;
    memPkg::queueCount_t count;
    logic doPop;

    assign notEmpty = (count != '0);
    assign head = entries[rdPtr];

    // a pop on an empty queue is dropped
    assign doPop = pop && notEmpty;

    // no full check, the requester never pushes without a credit
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per served entry
            creditReturn <= doPop;
        end
    end

endmodule

`default_nettype wire

//--- hdl/memPkg.sv
`default_nettype none

package memPkg;

    // 1 KiB byte-wide RAM
    localparam int MemAddrWidth = 10;
    localparam int MemBytes = 1 << MemAddrWidth;

    // entries per request queue, also the credits a requester starts with
    localparam int QueueDepth = 2;
    localparam int QueuePtrWidth = $clog2(QueueDepth);
    localparam int QueueCountWidth = $clog2(QueueDepth + 1);

    // stage counter covers 0 to 4
    localparam int StageWidth = 3;

    typedef logic [MemAddrWidth-1:0] memAddr_t;
    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;
    typedef logic [StageWidth-1:0] stage_t;
    typedef logic [QueuePtrWidth-1:0] queuePtr_t;
    typedef logic [QueueCountWidth-1:0] queueCount_t;

    typedef enum logic [1:0] {
        LenByte = 2'd0,
        LenHalf = 2'd1,
        LenWord = 2'd2
    } lenCode_t;

    typedef enum logic [1:0] {
        Idle,
        ReadInst,
        ReadData,
        WriteData
    } ctrlState_t;

    typedef struct packed {
        logic valid;
        memAddr_t addr;
    } instReq_t;

    typedef struct packed {
        logic valid;
        logic isStore;
        lenCode_t len;
        memAddr_t addr;
        word_t wdata;
    } dataReq_t;

    typedef struct packed {
        logic valid;
        word_t inst;
    } instRsp_t;

    // rdata is zero for stores
    typedef struct packed {
        logic valid;
        logic isStore;
        word_t rdata;
    } dataRsp_t;

    typedef struct packed {
        logic en;
        logic we;
        memAddr_t addr;
        byte_t wdata;
    } ramReq_t;

endpackage

`default_nettype wire
